/* dv/fx_arith_patterns.txt */
// columns as hex nibbles: op(1) a(4) b(4) expected result(4) expected flags(1)
// op 0 add, 1 sub, 2 mul, 3 div; flags bit 1 sat, bit 0 div_zero; Q8.8 words
00100020003000
0FF000080FF800
0700020007FFF2
08000FFFF80002
00000000000000
10300010002000
101000280FE800
18000000180002
17FFFFFFF7FFF2
1FFFF0001FFFE0
20200030006000
2FF000180FE800
20080008000400
20001000100000
2FFFF0001FFFF0
2FF80FF8000400
20003FF00FFFD0
2400004007FFF2
24000FC0080002
30300020001800
3FD000200FE800
30100000355550
3FF000003AAAB0
30001FE0000000
30100010001000
37FFF00017FFF2
38000FFFF7FFF2
3050000007FFF3
3FB00000080003
3000000007FFF3

/* dv/fx_arith_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the fixed-point unit: plays the pattern file
// through the request stream, random back-pressure on responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_arith_tb;

    import fxp_fmt_pkg::*;
    import fxp_op_pkg::*;

    localparam int N_PAT       = 30;
    localparam int RESET_CYC   = 10;
    localparam int INIT_STALL  = 30;  // out_ready low at start so the credits run out
    localparam int TIMEOUT_CYC = 20 * N_PAT + RESET_CYC + 50;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    fx_req_t in_req;
    logic    out_valid;
    logic    out_ready;
    fx_rsp_t out_rsp;

    logic [55:0] patterns [0:N_PAT-1];  // op, a, b, result, flags as hex nibbles
    integer      seed;
    int          sent_count;
    int          recv_count;
    int          cycles;
    logic        saw_full;             // in_ready seen low

    fx_arith_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input fx_word_t got, input fx_word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_run("stopping at the first mismatch");
        end
    endtask

    task automatic check_flags(input string name, input fx_flags_t got, input fx_flags_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            fail_run("stopping at the first mismatch");
        end
    endtask

    task automatic check_op(input string name, input fx_op_e got, input fx_op_e exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %s, expected %s", $time, name,
                     got.name(), exp.name());
            fail_run("stopping at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            fail_run("stopping at the first mismatch");
        end
    endtask

    // request fields of pattern line i
    function automatic fx_req_t req_of(input int i);
        fx_req_t r;
        r.op = fx_op_e'(patterns[i][53:52]);
        r.a  = patterns[i][51:36];
        r.b  = patterns[i][35:20];
        return r;
    endfunction

    always @(posedge clk) begin : watch_streams
        fx_req_t exp_req;
        if (rst_n) begin
            // credits are the requests accepted and not yet answered
            check_bit("in_ready", in_ready, (sent_count - recv_count) < FP_FIFO_DEPTH);
            if (in_valid && in_ready) begin
                sent_count++;
            end
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (recv_count >= N_PAT) begin
                    fail_run("a response arrived with no request left to match it");
                end else begin
                    exp_req = req_of(recv_count);
                    check_op("out_rsp.op", out_rsp.op, exp_req.op);
                    check_word("out_rsp.result", out_rsp.result,
                               fx_word_t'(patterns[recv_count][19:4]));
                    check_flags("out_rsp.flags", out_rsp.flags,
                                fx_flags_t'(patterns[recv_count][1:0]));
                    recv_count++;
                end
            end
        end
    end

    always @(posedge clk) begin : count_cycles
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            fail_run($sformatf("timeout: %0d of %0d responses seen after %0d cycles",
                               recv_count, N_PAT, cycles));
        end
    end

    // long stall first, then random stretches of back-pressure
    initial begin : drive_out_ready
        int hold;
        hold = 0;
        wait (rst_n === 1'b1);
        repeat (INIT_STALL) @(negedge clk);
        forever begin
            @(negedge clk);
            if (hold > 0) begin
                hold--;
                out_ready = 1'b0;
            end else if (($random(seed) & 31) == 0) begin
                hold      = 8 + ($random(seed) & 15);
                out_ready = 1'b0;
            end else begin
                out_ready = ($random(seed) & 3) != 0;
            end
        end
    end

    initial begin : main_flow
        int next_req;
        seed       = 63136;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b0;
        sent_count = 0;
        recv_count = 0;
        cycles     = 0;
        saw_full   = 1'b0;
        next_req   = 0;
        $readmemh("dv/fx_arith_patterns.txt", patterns);
        if (^patterns[N_PAT-1] === 1'bx) begin
            fail_run("pattern file is missing or shorter than expected");
        end
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b1);  // idle state after reset
        check_bit("out_valid", out_valid, 1'b0);
        while (next_req < N_PAT) begin
            if (in_valid && sent_count > next_req) begin  // taken at the last edge
                next_req++;
                in_valid = 1'b0;
            end
            if (!in_valid && next_req < N_PAT && ($random(seed) & 3) != 0) begin
                in_valid = 1'b1;
                in_req   = req_of(next_req);
            end
            @(negedge clk);
        end
        wait (recv_count == N_PAT);
        repeat (10) @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);  // nothing duplicated
        if (!saw_full) begin
            fail_run("in_ready never dropped while out_ready was held low");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* logic/fx_addsub.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturating adder/subtractor, result and flag one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_addsub (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fxp_fmt_pkg::fx_word_t a,
    input  fxp_fmt_pkg::fx_word_t b,
    input  logic                 sub,
    output fxp_fmt_pkg::fx_word_t sum,
    output logic                 sat
);

    import fxp_fmt_pkg::*;

    logic signed [FP_WIDTH:0] wide;  // one guard bit
    fx_word_t                 clamped;
    logic                     ovf;

    always_comb begin
        if (sub) begin
            wide = {a[FP_WIDTH-1], a} - {b[FP_WIDTH-1], b};
        end else begin
            wide = {a[FP_WIDTH-1], a} + {b[FP_WIDTH-1], b};
        end
        // guard bit and word sign disagree on overflow
        ovf = wide[FP_WIDTH] != wide[FP_WIDTH-1];
        if (!ovf) begin
            clamped = wide[FP_WIDTH-1:0];
        end else if (wide[FP_WIDTH]) begin
            clamped = FX_MIN;
        end else begin
            clamped = FX_MAX;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
            sat <= 1'b0;
        end else begin
            sum <= clamped;
            sat <= ovf;
        end
    end

endmodule

`default_nettype wire

/* logic/fx_arith_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-point arithmetic unit top: valid/ready request stream
// in, in-order valid/ready response stream out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_arith_unit #(
    parameter int QFRAC      = fxp_fmt_pkg::FP_QFRAC,
    parameter int LATENCY    = fxp_fmt_pkg::FP_DIV_LATENCY,  // at least 1
    parameter int FIFO_DEPTH = fxp_fmt_pkg::FP_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  fxp_op_pkg::fx_req_t in_req,
    output logic                out_valid,
    input  logic                out_ready,
    output fxp_op_pkg::fx_rsp_t out_rsp
);

    import fxp_op_pkg::*;

    logic    in_fire;
    logic    rsp_valid;
    fx_rsp_t rsp;

    assign in_fire = in_valid & in_ready;  // request accepted this edge

    fx_exec #(
        .QFRAC   (QFRAC),
        .LATENCY (LATENCY)
    ) exec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_fire   (in_fire),
        .in_req    (in_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // buffer also owns the request-side ready
    fx_result_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (rsp_valid),
        .wr_rsp    (rsp),
        .in_fire   (in_fire),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

endmodule

`default_nettype wire

/* logic/fx_div.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined fixed-point divider, LATENCY+1 cycles in to out.
// truncates toward zero, clamps, flags a zero divisor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_div #(
    parameter int QFRAC   = fxp_fmt_pkg::FP_QFRAC,
    parameter int LATENCY = fxp_fmt_pkg::FP_DIV_LATENCY
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fxp_fmt_pkg::fx_word_t a,
    input  fxp_fmt_pkg::fx_word_t b,
    output fxp_fmt_pkg::fx_word_t quot,
    output logic                 sat,
    output logic                 div_zero
);

    import fxp_fmt_pkg::*;

    // extra bit so MIN / -1 style quotients keep their sign
    localparam int FULLW = FP_WIDTH + QFRAC + 1;

    logic signed [FULLW-1:0] num_scaled;
    logic signed [FULLW-1:0] den_ext;
    logic signed [FULLW-1:0] raw_quot;
    logic                    den_zero;

    always_comb begin
        num_scaled = {{(QFRAC+1){a[FP_WIDTH-1]}}, a};
        num_scaled = num_scaled <<< QFRAC;
        den_zero   = b == '0;
        den_ext    = {{(QFRAC+1){b[FP_WIDTH-1]}}, b};
        if (den_zero) begin
            den_ext = FULLW'(1);  // keeps the divider defined, result replaced later
        end
        raw_quot = num_scaled / den_ext;
    end

    logic signed [FULLW-1:0] q_pipe   [0:LATENCY-1];
    logic                    dz_pipe  [0:LATENCY-1];
    logic                    neg_pipe [0:LATENCY-1];

    always_ff @(posedge clk) begin
        q_pipe[0]   <= raw_quot;
        dz_pipe[0]  <= den_zero;
        neg_pipe[0] <= a[FP_WIDTH-1];
        for (int i = 1; i < LATENCY; i++) begin
            q_pipe[i]   <= q_pipe[i-1];
            dz_pipe[i]  <= dz_pipe[i-1];
            neg_pipe[i] <= neg_pipe[i-1];
        end
    end

    logic signed [FULLW-1:0] q_last;
    fx_word_t                clamped;
    logic                    ovf;

    always_comb begin
        q_last = q_pipe[LATENCY-1];
        ovf    = q_last[FULLW-1:FP_WIDTH-1] != {(FULLW-FP_WIDTH+1){q_last[FULLW-1]}};
        if (dz_pipe[LATENCY-1]) begin
            clamped = neg_pipe[LATENCY-1] ? FX_MIN : FX_MAX;  // sign of numerator
        end else if (!ovf) begin
            clamped = q_last[FP_WIDTH-1:0];
        end else if (q_last[FULLW-1]) begin
            clamped = FX_MIN;
        end else begin
            clamped = FX_MAX;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quot     <= '0;
            sat      <= 1'b0;
            div_zero <= 1'b0;
        end else begin
            quot     <= clamped;
            sat      <= ovf | dz_pipe[LATENCY-1];
            div_zero <= dz_pipe[LATENCY-1];
        end
    end

endmodule

`default_nettype wire

/* logic/fx_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execution pipeline: feeds all three units every cycle, lines
// their results up at LATENCY+1 and picks the one for the op
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_exec #(
    parameter int QFRAC   = fxp_fmt_pkg::FP_QFRAC,
    parameter int LATENCY = fxp_fmt_pkg::FP_DIV_LATENCY
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_fire,
    input  fxp_op_pkg::fx_req_t in_req,
    output logic                rsp_valid,
    output fxp_op_pkg::fx_rsp_t rsp
);

    import fxp_fmt_pkg::*;
    import fxp_op_pkg::*;

    typedef struct packed {
        fx_word_t  result;
        fx_flags_t flags;
    } unit_out_t;

    logic      sub_sel;
    fx_word_t  as_sum, mul_prod, div_quot;
    logic      as_sat, mul_sat, div_sat, div_dz;
    unit_out_t as_out, mul_out, as_al, mul_al;

    assign sub_sel = in_req.op == OP_SUB;

    fx_addsub addsub_i (.clk(clk), .rst_n(rst_n), .a(in_req.a), .b(in_req.b),
                        .sub(sub_sel), .sum(as_sum), .sat(as_sat));

    fx_mul #(.QFRAC(QFRAC)) mul_i (.clk(clk), .rst_n(rst_n), .a(in_req.a), .b(in_req.b),
                                   .prod(mul_prod), .sat(mul_sat));

    fx_div #(.QFRAC(QFRAC), .LATENCY(LATENCY)) div_i (
        .clk(clk), .rst_n(rst_n), .a(in_req.a), .b(in_req.b),
        .quot(div_quot), .sat(div_sat), .div_zero(div_dz)
    );

    assign as_out  = '{result: as_sum, flags: '{sat: as_sat, div_zero: 1'b0}};
    assign mul_out = '{result: mul_prod, flags: '{sat: mul_sat, div_zero: 1'b0}};

    // add/sub is 1 cycle, needs LATENCY more
    unit_out_t as_dly [0:LATENCY-1];
    always_ff @(posedge clk) begin
        as_dly[0] <= as_out;
        for (int i = 1; i < LATENCY; i++) begin
            as_dly[i] <= as_dly[i-1];
        end
    end
    assign as_al = as_dly[LATENCY-1];

    // mul is 2 cycles, needs LATENCY-1 more, possibly none
    if (LATENCY > 1) begin : g_mul_dly
        unit_out_t mul_dly [0:LATENCY-2];
        always_ff @(posedge clk) begin
            mul_dly[0] <= mul_out;
            for (int i = 1; i < LATENCY - 1; i++) begin
                mul_dly[i] <= mul_dly[i-1];
            end
        end
        assign mul_al = mul_dly[LATENCY-2];
    end else begin : g_mul_direct
        assign mul_al = mul_out;
    end

    logic [LATENCY:0] v_pipe;
    fx_op_e           op_pipe [0:LATENCY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[LATENCY-1:0], in_fire};
        end
    end

    always_ff @(posedge clk) begin
        op_pipe[0] <= in_req.op;
        for (int i = 1; i <= LATENCY; i++) begin
            op_pipe[i] <= op_pipe[i-1];
        end
    end

    always_comb begin
        rsp_valid = v_pipe[LATENCY];
        rsp.op    = op_pipe[LATENCY];
        case (op_pipe[LATENCY])
            OP_ADD, OP_SUB: {rsp.result, rsp.flags} = as_al;
            OP_MUL:         {rsp.result, rsp.flags} = mul_al;
            default: begin  // OP_DIV
                rsp.result         = div_quot;
                rsp.flags.sat      = div_sat;
                rsp.flags.div_zero = div_dz;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/fx_mul.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage fixed-point multiplier; floor shift by QFRAC, then
// clamp to the word range. result lands 2 cycles after inputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_mul #(
    parameter int QFRAC = fxp_fmt_pkg::FP_QFRAC
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fxp_fmt_pkg::fx_word_t a,
    input  fxp_fmt_pkg::fx_word_t b,
    output fxp_fmt_pkg::fx_word_t prod,
    output logic                 sat
);

    import fxp_fmt_pkg::*;

    localparam int PW = 2 * FP_WIDTH;

    logic signed [PW-1:0] prod_full;  // stage one, full product
    logic signed [PW-1:0] shifted;
    fx_word_t             clamped;
    logic                 ovf;

    always_ff @(posedge clk) begin
        prod_full <= a * b;
    end

    always_comb begin
        shifted = prod_full >>> QFRAC;  // arithmetic, rounds toward -inf
        // all dropped high bits must copy the word sign
        ovf = shifted[PW-1:FP_WIDTH-1] != {(PW-FP_WIDTH+1){shifted[PW-1]}};
        if (!ovf) begin
            clamped = shifted[FP_WIDTH-1:0];
        end else if (shifted[PW-1]) begin
            clamped = FX_MIN;
        end else begin
            clamped = FX_MAX;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod <= '0;
            sat  <= 1'b0;
        end else begin
            prod <= clamped;
            sat  <= ovf;
        end
    end

endmodule

`default_nettype wire

/* logic/fx_result_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through response FIFO; in_ready comes from a credit count
// of stored entries plus requests still in the exec pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module fx_result_fifo #(
    parameter int DEPTH = fxp_fmt_pkg::FP_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_valid,
    input  fxp_op_pkg::fx_rsp_t wr_rsp,
    input  logic                in_fire,
    output logic                in_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output fxp_op_pkg::fx_rsp_t out_rsp
);

    import fxp_op_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    fx_rsp_t        mem [0:DEPTH-1];
    logic [AW-1:0]  wr_ptr, rd_ptr;
    logic [CW-1:0]  count;    // entries held
    logic [CW-1:0]  credits;  // entries held + requests in flight
    logic           out_fire;

    assign out_fire  = out_valid & out_ready;
    assign out_valid = count != '0;
    assign out_rsp   = mem[rd_ptr];             // head shows without a read cycle
    assign in_ready  = credits < CW'(DEPTH);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_rsp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (out_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // credits bound count, so a write never finds the buffer full
            case ({wr_valid, out_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({in_fire, out_fire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/fxp_fmt_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// number format of the fixed-point unit: word width, default
// fraction bits, pipeline and FIFO defaults, saturation limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fxp_fmt_pkg;

    localparam int FP_WIDTH       = 16;  // bits per word
    localparam int FP_QFRAC       = 8;   // default fraction bits
    localparam int FP_DIV_LATENCY = 4;   // divider stages after its first register
    localparam int FP_FIFO_DEPTH  = 8;   // response buffer entries

    // two's complement Q word, binary point set by QFRAC
    typedef logic signed [FP_WIDTH-1:0] fx_word_t;

    // clamp targets on overflow
    localparam fx_word_t FX_MAX = {1'b0, {(FP_WIDTH-1){1'b1}}};
    localparam fx_word_t FX_MIN = {1'b1, {(FP_WIDTH-1){1'b0}}};

endpackage

`default_nettype wire

/* logic/fxp_op_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operations of the arithmetic unit: opcode encoding and the
// request, flag and response structs carried on the streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package fxp_op_pkg;

    import fxp_fmt_pkg::*;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_DIV = 2'd3
    } fx_op_e;

    // request beat, 34 bits
    typedef struct packed {
        fx_op_e   op;
        fx_word_t a;
        fx_word_t b;
    } fx_req_t;

    typedef struct packed {
        logic sat;       // result was clamped
        logic div_zero;  // divisor was zero
    } fx_flags_t;

    // response beat, 20 bits; op is echoed back
    typedef struct packed {
        fx_op_e    op;
        fx_word_t  result;
        fx_flags_t flags;
    } fx_rsp_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f --top-module fx_arith_tb \
        -Mdir obj_dir -o fx_arith_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/fx_arith_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* src.f */
logic/fxp_fmt_pkg.sv
logic/fxp_op_pkg.sv
logic/fx_addsub.sv
logic/fx_mul.sv
logic/fx_div.sv
logic/fx_exec.sv
logic/fx_result_fifo.sv
logic/fx_arith_unit.sv
dv/fx_arith_tb.sv
